//--- files.f
+incdir+.
aq_pkg.sv
bus_sync.sv
io_ctrl.sv
mem_map.sv
keyboard_matrix.sv
aq_bus_top.sv
tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bus controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f files.f --top-module tb_top -o tb_top

sim_out=$(./obj_dir/tb_top)
echo "$sim_out"

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

//--- tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////
// Bus cycles
//////////////////////////////

// Long enough for the strobe synchroniser to see the write
task automatic io_write(input data_t port, input data_t val);
    @(posedge sysclk);
    #1;
    addr    = {8'h00, port};
    data_in = val;
    iorq_n  = 1'b0;
    wr_n    = 1'b0;
    repeat (5) @(posedge sysclk);
    #1;
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    if (port[7:2] == 6'h3C) begin
        bank_model[port[1:0]] = val;    // Bank ports F0-F3
    end
endtask

// Row byte goes out on A15-A8 as for an IN r,(C)
task automatic io_read(input data_t port, input data_t row, input data_t exp,
                       input logic exp_oe);
    @(posedge sysclk);
    #1;
    addr   = {row, port};
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    @(posedge sysclk);
    #5;
    check_bit("data_oe", data_oe, exp_oe);
    if (exp_oe) begin
        check_value("data_out", data_out, exp);
    end
    @(posedge sysclk);
    #1;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
endtask

task automatic mem_access(input addr_t a, input logic write, input mem_sel_t exp);
    @(posedge sysclk);
    #1;
    addr   = a;
    mreq_n = 1'b0;
    rd_n   = write;
    wr_n   = !write;
    #5;
    check_bit("ram_ce_n", ram_ce_n, exp.ram_ce_n);
    check_bit("rom_ce_n", rom_ce_n, exp.rom_ce_n);
    check_bit("we_n", we_n, exp.we_n);
    check_value("ba", {3'b000, ba}, {3'b000, exp.ba});
    @(posedge sysclk);
    #1;
    mreq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
endtask

//////////////////////////////
// Reference models
//////////////////////////////
function automatic mem_sel_t predict_mem(input addr_t a, input logic write, input data_t bank);
    mem_sel_t m;
    int       pg;
    pg         = int'(bank[5:0]);
    m.ram_ce_n = 1'b1;
    m.rom_ce_n = 1'b1;
    m.we_n     = 1'b1;
    m.ba       = bank[4:0];
    if (bank[6] && a[13:11] == 3'b111) begin
        m.ram_ce_n = 1'b0;              // System RAM ignores the RO bit
        m.ba       = 5'd0;
        m.we_n     = !write;
    end else if (!(write && bank[7])) begin
        if (pg <= 15) begin
            m.rom_ce_n = 1'b0;
        end else if (pg >= 32) begin
            m.ram_ce_n = 1'b0;
        end
        m.we_n = !((write && pg <= 15) || (write && pg >= 32));
    end
    return m;
endfunction

// A column reads low if any selected row has that key down
function automatic data_t expected_keys(input keys_t k, input data_t rows);
    data_t result;
    result = 8'hFF;
    for (int col = 0; col < 8; col++) begin
        for (int r = 0; r < 8; r++) begin
            if (rows[r] == 1'b0 && k[r][col] == 1'b0) begin
                result[col] = 1'b0;
            end
        end
    end
    return result;
endfunction

//////////////////////////////
// Directed tests
//////////////////////////////
task automatic test_reset_values();
    io_read(8'hF0, 8'h00, 8'hC0, 1'b1);
    io_read(8'hF1, 8'h00, 8'h21, 1'b1);
    io_read(8'hF2, 8'h00, 8'h22, 1'b1);
    io_read(8'hF3, 8'h00, 8'h13, 1'b1);
    check_bit("cassette_out", cassette_out, 1'b0);
    check_bit("printer_out", printer_out, 1'b0);
    check_bit("ram_ce_n", ram_ce_n, 1'b1);      // mreq_n is idle here
    check_bit("rom_ce_n", rom_ce_n, 1'b1);
    check_bit("we_n", we_n, 1'b1);
endtask

task automatic test_io_registers();
    data_t val;
    for (int i = 0; i < 4; i++) begin
        val = data_t'($urandom);
        io_write(IO_BANK0 + data_t'(i), val);
    end
    for (int i = 0; i < 4; i++) begin
        io_read(IO_BANK0 + data_t'(i), 8'h00, bank_model[i], 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
        val = data_t'($urandom);
        io_write(8'hFC, val);
        check_bit("cassette_out", cassette_out, val[0]);
        io_write(8'hFE, ~val);
        check_bit("printer_out", printer_out, ~val[0]);
        cassette_in = val[1];
        printer_in  = val[2];
        io_read(8'hFC, 8'h00, {7'b0, val[1]}, 1'b1);
        io_read(8'hFE, 8'h00, {7'b0, val[2]}, 1'b1);
    end
    io_read(8'hFD, 8'h00, 8'h00, 1'b1);
    // Unmapped ports leave the bus alone
    io_read(8'h00, 8'h00, 8'h00, 1'b0);
    io_read(8'h7F, 8'h00, 8'h00, 1'b0);
    io_read(8'hF4, 8'h00, 8'h00, 1'b0);
    io_read(8'hFB, 8'h00, 8'h00, 1'b0);
endtask

task automatic test_bank_decode();
    addr_t a;
    data_t val;
    logic [1:0] w;
    io_write(8'hF1, 8'h14);                                 // Page 20, no device
    mem_access(16'h4321, 1'b0, {1'b1, 1'b1, 1'b1, 5'd20});  // ram, rom, we, ba
    for (int i = 0; i < 12; i++) begin
        w      = 2'($urandom);
        val    = data_t'($urandom);
        val[6] = 1'b0;
        io_write(IO_BANK0 + data_t'(w), val);
        a        = addr_t'($urandom);
        a[15:14] = w;
        mem_access(a, 1'b0, predict_mem(a, 1'b0, bank_model[w]));
        mem_access(a, 1'b1, predict_mem(a, 1'b1, bank_model[w]));
    end
endtask

task automatic test_overlay();
    addr_t a;
    data_t val;
    logic [1:0] w;
    for (int i = 0; i < 4; i++) begin
        w        = 2'(i);
        val      = data_t'($urandom);
        val[7:6] = 2'b11;               // RO with overlay
        io_write(IO_BANK0 + data_t'(w), val);
        a          = addr_t'($urandom);
        a[15:14]   = w;
        a[13:11]   = 3'b111;
        mem_access(a, 1'b0, {1'b0, 1'b1, 1'b1, 5'd0});
        mem_access(a, 1'b1, {1'b0, 1'b1, 1'b0, 5'd0});
        val[6] = 1'b0;
        io_write(IO_BANK0 + data_t'(w), val);
        mem_access(a, 1'b0, predict_mem(a, 1'b0, val));
        mem_access(a, 1'b1, predict_mem(a, 1'b1, val));
    end
endtask

task automatic test_read_only();
    io_write(8'hF2, 8'h85);                                 // RO, ROM page 5
    mem_access(16'h8123, 1'b1, {1'b1, 1'b1, 1'b1, 5'd5});
    mem_access(16'h8123, 1'b0, {1'b1, 1'b0, 1'b1, 5'd5});
    io_write(8'hF2, 8'h05);
    mem_access(16'h8123, 1'b1, {1'b1, 1'b0, 1'b0, 5'd5});
    io_write(8'hF2, 8'hA8);                                 // RO, RAM page 40
    mem_access(16'hA456, 1'b1, {1'b1, 1'b1, 1'b1, 5'd8});
    io_write(8'hF2, 8'h28);
    mem_access(16'hA456, 1'b1, {1'b0, 1'b1, 1'b0, 5'd8});
endtask

task automatic test_keyboard();
    data_t row;
    for (int i = 0; i < 12; i++) begin
        @(posedge sysclk);
        #1;
        for (int r = 0; r < 8; r++) begin
            keys[r] = data_t'($urandom);
        end
        row = data_t'($urandom);
        if (i == 0) begin
            row = 8'hFF;                // Nothing selected
        end else if (i == 1) begin
            row = 8'h00;
        end
        io_read(8'hFF, row, expected_keys(keys, row), 1'b1);
    end
endtask

`endif

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top
    import aq_pkg::*;
();

    localparam int MAX_CYCLES = 3000;   // About five times the test length

    logic       sysclk;
    logic       reset;

    // DUT pins
    addr_t      addr;
    logic       mreq_n;
    logic       iorq_n;
    logic       rd_n;
    logic       wr_n;
    data_t      data_in;
    data_t      data_out;
    logic       data_oe;
    keys_t      keys;
    logic       cassette_in;
    logic       printer_in;
    logic       cassette_out;
    logic       printer_out;
    logic       ram_ce_n;
    logic       rom_ce_n;
    logic       we_n;
    logic [4:0] ba;

    data_t      bank_model [4];     // Expected contents of F0-F3
    int         errors;
    int         cycles;

    aq_bus_top #(
        .SYNC_STAGES(3)
    ) dut (
        .sysclk      (sysclk),
        .reset       (reset),
        .addr        (addr),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .data_in     (data_in),
        .data_out    (data_out),
        .data_oe     (data_oe),
        .keys        (keys),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .cassette_out(cassette_out),
        .printer_out (printer_out),
        .ram_ce_n    (ram_ce_n),
        .rom_ce_n    (rom_ce_n),
        .we_n        (we_n),
        .ba          (ba)
    );

    //////////////////////////////
    // Clock and run limit
    //////////////////////////////
    always #10 sysclk = ~sysclk;    // 20 ns period

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////
    // Compare helpers
    //////////////////////////////
    task automatic check_value(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    `include "tb_tasks.svh"

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        sysclk      = 1'b0;
        reset       = 1'b1;
        addr        = '0;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        data_in     = 8'h00;
        keys        = '1;           // No key pressed
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        errors      = 0;
        cycles      = 0;

        bank_model[0] = 8'hC0;
        bank_model[1] = 8'h21;
        bank_model[2] = 8'h22;
        bank_model[3] = 8'h13;

        void'($urandom(32'h9985_7892));

        repeat (5) @(posedge sysclk);
        #1;
        reset = 1'b0;

        test_reset_values();
        test_io_registers();
        test_bank_decode();
        test_overlay();
        test_read_only();
        test_keyboard();

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- aq_bus_top.sv
`timescale 1ns/1ps

module aq_bus_top
    import aq_pkg::*;
#(
    parameter int SYNC_STAGES = 3
) (
    input  logic       sysclk,
    input  logic       reset,

    // Z80 bus
    input  addr_t      addr,
    input  logic       mreq_n,
    input  logic       iorq_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  data_t      data_in,
    output data_t      data_out,
    output logic       data_oe,

    // Peripherals
    input  keys_t      keys,
    input  logic       cassette_in,
    input  logic       printer_in,
    output logic       cassette_out,
    output logic       printer_out,

    // External memory
    output logic       ram_ce_n,
    output logic       rom_ce_n,
    output logic       we_n,
    output logic [4:0] ba
);

    cpu_bus_t   bus;
    logic       bus_write;
    data_t      wrdata;
    data_t      key_data;
    bank_regs_t banks;
    mem_sel_t   mem_sel;

    assign bus = '{addr: addr, mreq_n: mreq_n, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n};

    //////////////////////////////
    // Bus side
    //////////////////////////////
    bus_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) bus_sync (
        .sysclk   (sysclk),
        .reset    (reset),
        .bus      (bus),
        .data_in  (data_in),
        .bus_read (),             // No read side effects yet
        .bus_write(bus_write),
        .wrdata   (wrdata)
    );

    io_ctrl io_ctrl (
        .sysclk      (sysclk),
        .reset       (reset),
        .bus         (bus),
        .bus_write   (bus_write),
        .wrdata      (wrdata),
        .key_data    (key_data),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .banks       (banks),
        .cassette_out(cassette_out),
        .printer_out (printer_out),
        .data_out    (data_out),
        .data_oe     (data_oe)
    );

    //////////////////////////////
    // Decoders
    //////////////////////////////
    mem_map mem_map (
        .bus    (bus),
        .banks  (banks),
        .mem_sel(mem_sel)
    );

    keyboard_matrix keyboard_matrix (
        .row_sel (bus.addr[15:8]),
        .keys    (keys),
        .key_data(key_data)
    );

    assign ram_ce_n = mem_sel.ram_ce_n;
    assign rom_ce_n = mem_sel.rom_ce_n;
    assign we_n     = mem_sel.we_n;
    assign ba       = mem_sel.ba;

endmodule

//--- keyboard_matrix.sv
`timescale 1ns/1ps

module keyboard_matrix
    import aq_pkg::*;
(
    input  data_t row_sel,     // A15-A8 of the port FF read
    input  keys_t keys,
    output data_t key_data
);

    // Active low on both sides, so pressed keys in any selected row pull the bit low
    always_comb begin
        key_data = 8'hFF;      // No row selected
        for (int i = 0; i < 8; i++) begin
            if (!row_sel[i]) begin
                key_data = key_data & keys[i];
            end
        end
    end

endmodule

//--- mem_map.sv
`timescale 1ns/1ps

module mem_map
    import aq_pkg::*;
(
    input  cpu_bus_t   bus,
    input  bank_regs_t banks,
    output mem_sel_t   mem_sel
);

    bank_reg_t bank;
    logic      mreq;
    logic      cpu_wr;
    logic      sel_sysram;
    logic      allow_sel_mem;
    logic      sel_rom;
    logic      sel_ram;

    //////////////////////////////
    // Window and page decode
    //////////////////////////////
    always_comb begin
        bank   = banks[bus.addr[15:14]];   // One register per 16 KB window
        mreq   = !bus.mreq_n;
        cpu_wr = !bus.wr_n;

        // Top 2 KB of a window with overlay on
        sel_sysram = mreq && bank.overlay && bus.addr[13:11] == 3'b111;

        // RO bank swallows writes to its page
        allow_sel_mem = mreq && !sel_sysram && !(cpu_wr && bank.ro);

        sel_rom = allow_sel_mem && bank.page[5:4] == 2'b00;     // Pages 0-15
        sel_ram = (allow_sel_mem && bank.page[5]) || sel_sysram; // Pages 32-63
        // Pages 16-31 select nothing

        mem_sel.ram_ce_n = !sel_ram;
        mem_sel.rom_ce_n = !sel_rom;

        // RO writes were already dropped in allow_sel_mem
        mem_sel.we_n = !(cpu_wr && (sel_ram || sel_rom));

        // System RAM sits at the start of page 32
        mem_sel.ba = sel_sysram ? 5'd0 : bank.page[4:0];
    end

endmodule

//--- io_ctrl.sv
`timescale 1ns/1ps

module io_ctrl
    import aq_pkg::*;
(
    input  logic       sysclk,
    input  logic       reset,

    input  cpu_bus_t   bus,
    input  logic       bus_write,
    input  data_t      wrdata,

    input  data_t      key_data,
    input  logic       cassette_in,
    input  logic       printer_in,

    output bank_regs_t banks,
    output logic       cassette_out,
    output logic       printer_out,

    output data_t      data_out,
    output logic       data_oe
);

    data_t port;

    logic  sel_io;
    logic  sel_bank;
    logic  sel_cassette;
    logic  sel_vsync_cpm;
    logic  sel_printer;
    logic  sel_keyb;
    logic  sel_mapped;

    //////////////////////////////
    // Port decode
    //////////////////////////////
    assign port   = bus.addr[7:0];     // Z80 puts the port on A7-A0
    assign sel_io = !bus.iorq_n;

    // Four consecutive bank ports, low two bits pick the register
    assign sel_bank      = sel_io && port[7:2] == IO_BANK0[7:2];
    assign sel_cassette  = sel_io && port == IO_CASSETTE;
    assign sel_vsync_cpm = sel_io && port == IO_VSYNC_CPM;   // Reads zero, writes dropped
    assign sel_printer   = sel_io && port == IO_PRINTER;
    assign sel_keyb      = sel_io && port == IO_KEYB;        // Read only

    assign sel_mapped = sel_bank | sel_cassette | sel_vsync_cpm | sel_printer | sel_keyb;

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks[0]     <= bank_reg_t'(BANK0_RESET);
            banks[1]     <= bank_reg_t'(BANK1_RESET);
            banks[2]     <= bank_reg_t'(BANK2_RESET);
            banks[3]     <= bank_reg_t'(BANK3_RESET);
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (bus_write) begin
            if (sel_bank) begin
                banks[port[1:0]] <= bank_reg_t'(wrdata);
            end
            if (sel_cassette) begin
                cassette_out <= wrdata[0];
            end
            if (sel_printer) begin
                printer_out <= wrdata[0];
            end
        end
    end

    //////////////////////////////
    // Read data
    //////////////////////////////
    always_comb begin
        data_out = 8'h00;
        if (sel_bank) begin
            data_out = data_t'(banks[port[1:0]]);
        end
        if (sel_cassette) begin
            data_out = {7'b0, cassette_in};
        end
        if (sel_printer) begin
            data_out = {7'b0, printer_in};
        end
        if (sel_keyb) begin
            data_out = key_data;    // Rows picked by A15-A8
        end
        // FD has no source here and stays zero
    end

    // Only drive the CPU data bus for our own ports
    assign data_oe = !bus.rd_n && sel_mapped;

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Register update must land while the CPU still holds its write strobe
    a_write_in_cycle : assert property (
        @(posedge sysclk) disable iff (reset)
        bus_write && sel_mapped |-> !bus.wr_n
    );

endmodule

//--- bus_sync.sv
`timescale 1ns/1ps

module bus_sync
    import aq_pkg::*;
#(
    parameter int SYNC_STAGES = 3
) (
    input  logic     sysclk,
    input  logic     reset,

    input  cpu_bus_t bus,
    input  data_t    data_in,

    output logic     bus_read,
    output logic     bus_write,
    output data_t    wrdata
);

    // Strobe history, bit 0 is the newest sample
    logic [SYNC_STAGES-1:0] rd_sync;
    logic [SYNC_STAGES-1:0] wr_sync;

    //////////////////////////////
    // Strobe synchronisers
    //////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_sync <= '1;      // Idle bus
            wr_sync <= '1;
        end else begin
            rd_sync <= {rd_sync[SYNC_STAGES-2:0], bus.rd_n};
            wr_sync <= {wr_sync[SYNC_STAGES-2:0], bus.wr_n};
        end
    end

    // Falling edge seen on the two oldest stages
    assign bus_read  = rd_sync[SYNC_STAGES-1 -: 2] == 2'b10;
    assign bus_write = wr_sync[SYNC_STAGES-1 -: 2] == 2'b10;

    // Data byte tracks the bus while the write strobe is low
    always_ff @(posedge sysclk) begin
        if (!bus.wr_n) begin
            wrdata <= data_in;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A Z80 never drives RD and WR in the same cycle
    a_no_rd_wr_pulse : assert property (
        @(posedge sysclk) disable iff (reset)
        !(bus_read && bus_write)
    );

endmodule

//--- aq_pkg.sv
package aq_pkg;

    //////////////////////////////
    // Basic widths
    //////////////////////////////
    typedef logic [15:0] addr_t;    // CPU address
    typedef logic [7:0]  data_t;    // Data byte
    typedef logic [5:0]  page_t;    // 16 KB page in the 1 MB space

    // One banking register as seen on ports F0-F3
    typedef struct packed {
        logic  ro;          // Writes blocked
        logic  overlay;     // System RAM at 3800-3FFF
        page_t page;
    } bank_reg_t;

    // Index 0 is window 0000-3FFF
    typedef bank_reg_t [3:0] bank_regs_t;

    // Z80 bus request, strobes active low
    typedef struct packed {
        addr_t addr;
        logic  mreq_n;
        logic  iorq_n;
        logic  rd_n;
        logic  wr_n;
    } cpu_bus_t;

    // Chip selects and bank address for the external memories
    typedef struct packed {
        logic       ram_ce_n;
        logic       rom_ce_n;
        logic       we_n;
        logic [4:0] ba;
    } mem_sel_t;

    // Row i lives in keys[i], a low bit is a pressed key
    typedef logic [7:0][7:0] keys_t;

    //////////////////////////////
    // I/O ports
    //////////////////////////////
    localparam data_t IO_BANK0     = 8'hF0;    // F0-F3 are the four bank registers
    localparam data_t IO_CASSETTE  = 8'hFC;
    localparam data_t IO_VSYNC_CPM = 8'hFD;
    localparam data_t IO_PRINTER   = 8'hFE;
    localparam data_t IO_KEYB      = 8'hFF;

    // Bank register values after reset
    localparam data_t BANK0_RESET = 8'hC0;     // RO + overlay, page 0 (boot ROM)
    localparam data_t BANK1_RESET = 8'h21;     // Page 33
    localparam data_t BANK2_RESET = 8'h22;     // Page 34
    localparam data_t BANK3_RESET = 8'h13;     // Page 19

endpackage
